// ==== verilog.f ====
+incdir+include
hw/ufi_pkg.sv
hw/UltraFastInterface.sv
hw/UfiRamBlock.sv
hw/UfiMemSubsystem.sv
tests/UfiMemSubsystem_properties.sv
tests/UfiMemSubsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module UfiMemSubsystem_tb \
	-f verilog.f \
	-o UfiMemSubsystem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/UfiMemSubsystem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// ==== tests/UfiMemSubsystem_tb.sv ====
/* Testbench for the memory bus subsystem. Directed priority, lockout and refresh cases,
   then a seeded random mix of all four masters, all checked against a cycle model. */
`timescale 1ns/100ps
`include "ufi_cfg.svh"

module UfiMemSubsystem_tb;

	import ufi_pkg::*;

	localparam int busBit        = `UFI_BUS_WIDTH;
	localparam int adrsBit       = `UFI_ADRS_BIT;
	localparam int depthBit      = `UFI_RAM_DEPTH_BIT;
	localparam int ramWords      = 1 << `UFI_RAM_DEPTH_BIT;
	localparam int period        = `UFI_REFRESH_PERIOD;
	localparam int blockStart    = `UFI_REFRESH_PERIOD - `UFI_REFRESH_CYCLES;
	localparam int retDelay      = 3;                  // RAM accept edge to rsp.rEd edge
	localparam int randCycles    = 2000;
	localparam int timeoutCycles = randCycles + 500;   // Directed part is about 320

	typedef struct packed
	{
		int                 due;    // Model cycle of rsp.rEd
		logic [busBit-1:0]  data;
		logic               known;  // Location holds a written value
	} expReadT;

	logic      iUfiClk;
	logic      rst;
	ufiReqT    reqMcs;
	ufiReqT    reqSpi;
	ufiReqT    reqAtb;
	ufiReqT    reqVtb;
	ufiRspT    rsp;
	logic      rdy;
	logic      rdyAtb;
	logic      rdyVtb;

	// Reference model state
	logic [busBit-1:0] memModel [ramWords];
	logic              memKnown [ramWords];
	ufiGrantE          owner;          // Bus owner after last edge
	ufiRamReqT         pend;           // Strobe travelling to the RAM
	expReadT           expQ [$];       // Reads waiting for rsp.rEd
	int                sinceRel;       // Refresh phase since reset release
	int                cyc;
	int                readsSeen;
	int                edgeCnt = 0;
	integer            seed;

	UfiMemSubsystem UfiMemSubsystem_i
	(
		.iUfiClk (iUfiClk),
		.rst     (rst),
		.reqMcs  (reqMcs),
		.reqSpi  (reqSpi),
		.reqAtb  (reqAtb),
		.reqVtb  (reqVtb),
		.rsp     (rsp),
		.rdy     (rdy),
		.rdyAtb  (rdyAtb),
		.rdyVtb  (rdyVtb)
	);

	bind UltraFastInterface UfiMemSubsystem_properties arbChecks (.*);

	initial
	begin
		iUfiClk = 1'b0;
		forever #4 iUfiClk = ~iUfiClk;     // 8 ns period
	end

	// Hang guard
	always @(posedge iUfiClk)
	begin
		edgeCnt++;
		if (edgeCnt == timeoutCycles)
		begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [adrsBit-1:0] randAdrs(input int low);
		logic [adrsBit-1:0] a;
		a = adrsBit'($random(seed));       // Junk in the ignored upper bits
		a[depthBit-1:0] = depthBit'(low);
		return a;
	endfunction

	function automatic ufiReqT makeReq(input logic valid, input logic ed, input ufiCmdE cmd,
		input logic [adrsBit-1:0] adrs, input logic [busBit-1:0] wd);
		ufiReqT r;
		r.valid = valid;
		r.ed    = ed;
		r.cmd   = cmd;
		r.adrs  = adrs;
		r.wd    = wd;
		return r;
	endfunction

	function automatic ufiReqT randReq(input int weight);
		ufiReqT r;
		r.valid = ($random(seed) & 7) < weight;     // weight out of 8
		r.ed    = r.valid && ($random(seed) & 1);
		r.cmd   = ufiCmdE'($random(seed) & 1);
		r.adrs  = randAdrs($random(seed) & 63);
		r.wd    = busBit'($random(seed));
		return r;
	endfunction

	// --------------------------------------------------
	// One clock edge plus the model for that edge
	// --------------------------------------------------
	task automatic stepCycle();
		logic                blocked;
		logic [depthBit-1:0] idx;
		expReadT             e;
		ufiReqT              win;
		ufiGrantE            nxt;
		@(posedge iUfiClk);
		#1;
		blocked = (sinceRel % period) >= blockStart;
		checkValue("rdy", rdy, !blocked);          // Ready seen one edge late
		idx = pend.adrs[depthBit-1:0];
		if (pend.wEd && !blocked)
		begin
			memModel[idx] = pend.wd;
			memKnown[idx] = 1'b1;
		end
		if (pend.rEd && !blocked)
		begin
			e.due   = cyc + retDelay;
			e.data  = memModel[idx];
			e.known = memKnown[idx];
			expQ.push_back(e);
		end
		checkValue("rsp.rEd", rsp.rEd, expQ.size() > 0 && expQ[0].due == cyc);
		if (rsp.rEd)
		begin
			e = expQ.pop_front();
			if (e.known)
				checkValue("rsp.rd", rsp.rd, e.data);
			readsSeen++;
		end
		// Priority with ATB/VTB lockout
		if (reqMcs.valid)
			nxt = GRANT_MCS;
		else if (reqSpi.valid)
			nxt = GRANT_SPI;
		else if (reqAtb.valid && owner != GRANT_VTB)
			nxt = GRANT_ATB;
		else if (reqVtb.valid && owner != GRANT_ATB)
			nxt = GRANT_VTB;
		else
			nxt = GRANT_NONE;
		case (nxt)
			GRANT_MCS: win = reqMcs;
			GRANT_SPI: win = reqSpi;
			GRANT_ATB: win = reqAtb;
			GRANT_VTB: win = reqVtb;
			default:   win = '0;
		endcase
		if (nxt == GRANT_MCS)
			win.cmd = UFI_WRITE;                   // MCS only writes
		if (nxt == GRANT_ATB)
			win.cmd = UFI_READ;                    // ATB only reads
		pend.adrs = win.adrs;
		pend.wd   = win.wd;
		pend.cmd  = win.cmd;
		pend.wEd  = win.ed && win.cmd == UFI_WRITE;
		pend.rEd  = win.ed && win.cmd == UFI_READ;
		owner = nxt;
		checkValue("rdyAtb", rdyAtb, owner == GRANT_ATB);
		checkValue("rdyVtb", rdyVtb, owner == GRANT_VTB);
		sinceRel++;
		cyc++;
	endtask

	// Idle all masters until every expected read is back
	task automatic drainReads();
		reqMcs = '0;
		reqSpi = '0;
		reqAtb = '0;
		reqVtb = '0;
		stepCycle();
		while (expQ.size() != 0)
			stepCycle();
	endtask

	task automatic readBack(input logic [adrsBit-1:0] a);
		reqSpi = makeReq(1'b1, 1'b1, UFI_READ, a, '0);
		stepCycle();
		drainReads();
	endtask

	initial
	begin
		int                 i;
		int                 m;
		logic [3:0]         mask;
		logic [adrsBit-1:0] a;
		seed = 32'h1f1ffb28;
		rst = 1'b1;
		reqMcs = '0;
		reqSpi = '0;
		reqAtb = '0;
		reqVtb = '0;
		pend = '0;
		owner = GRANT_NONE;
		sinceRel = 0;
		cyc = 0;
		readsSeen = 0;
		for (i = 0; i < ramWords; i++)
			memKnown[i] = 1'b0;
		repeat (4) @(posedge iUfiClk);
		#1;
		checkValue("rsp.rEd", rsp.rEd, 0);         // Reset values
		checkValue("rdy", rdy, 0);
		checkValue("rdyAtb", rdyAtb, 0);
		checkValue("rdyVtb", rdyVtb, 0);
		rst = 1'b0;

		// --------------------------------------------------
		// MCS fill then SPI read back, upper bits differ
		// --------------------------------------------------
		for (i = 0; i < 64; i++)
		begin
			reqMcs = makeReq(1'b1, 1'b1, UFI_READ, randAdrs(i), busBit'($random(seed)));
			stepCycle();
		end
		reqMcs = '0;
		for (i = 0; i < 64; i++)
		begin
			reqSpi = makeReq(1'b1, 1'b1, UFI_READ, randAdrs(i), '0);
			stepCycle();
		end
		drainReads();

		// Every multi-master mix on one location
		for (m = 3; m < 16; m++)
		begin
			mask = 4'(m);
			if ($countones(mask) > 1)
			begin
				a = randAdrs(200 + m);
				reqMcs = makeReq(mask[0], mask[0], UFI_WRITE, a, busBit'($random(seed)));
				reqSpi = makeReq(mask[1], mask[1], UFI_WRITE, a, busBit'($random(seed)));
				reqAtb = makeReq(mask[2], mask[2], UFI_READ, a, '0);
				reqVtb = makeReq(mask[3], mask[3], UFI_WRITE, a, busBit'($random(seed)));
				stepCycle();
				reqMcs = '0;
				reqAtb = '0;
				reqVtb = '0;
				readBack(a);
			end
		end

		// --------------------------------------------------
		// Lockout, ATB first then VTB first
		// --------------------------------------------------
		a = randAdrs(300);
		reqMcs = makeReq(1'b1, 1'b1, UFI_WRITE, a, 8'h5a);
		stepCycle();
		reqMcs = '0;
		for (i = 0; i < 6; i++)
		begin
			reqAtb = makeReq(1'b1, 1'b1, UFI_READ, randAdrs(i), '0);
			reqVtb = makeReq(1'b1, 1'b1, UFI_WRITE, a, busBit'($random(seed)));
			stepCycle();
		end
		drainReads();
		readBack(a);                               // VTB data must be absent
		reqVtb = makeReq(1'b1, 1'b0, UFI_READ, a, '0);
		stepCycle();
		for (i = 0; i < 6; i++)
		begin
			reqVtb = makeReq(1'b1, 1'b1, UFI_READ, randAdrs(i), '0);
			reqAtb = makeReq(1'b1, 1'b1, UFI_READ, randAdrs(i + 10), '0);
			stepCycle();
		end
		drainReads();

		// Write and read aimed at the refresh window
		a = randAdrs(400);
		reqMcs = makeReq(1'b1, 1'b1, UFI_WRITE, a, 8'h3c);
		stepCycle();
		reqMcs = '0;
		while ((sinceRel + 1) % period != blockStart)
			stepCycle();
		reqMcs = makeReq(1'b1, 1'b1, UFI_WRITE, a, 8'hc3);
		stepCycle();
		reqMcs = '0;
		reqSpi = makeReq(1'b1, 1'b1, UFI_READ, a, '0);
		stepCycle();
		drainReads();
		readBack(a);

		// --------------------------------------------------
		// Random mix
		// --------------------------------------------------
		readsSeen = 0;                             // Random-phase returns only
		for (i = 0; i < randCycles; i++)
		begin
			reqMcs = randReq(1);
			reqSpi = randReq(1);
			reqAtb = randReq(3);
			reqVtb = randReq(3);
			stepCycle();
		end
		drainReads();
		checkValue("readsSeen nonzero", readsSeen > 0, 1);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== tests/UfiMemSubsystem_properties.sv ====
/* Concurrent checks on the arbiter, bound into every UltraFastInterface instance */
`timescale 1ns/100ps

module UfiMemSubsystem_properties
(
	input logic               iUfiClk,
	input logic               rst,
	input ufi_pkg::ufiReqT    reqMcs,
	input ufi_pkg::ufiReqT    reqSpi,
	input ufi_pkg::ufiReqT    reqAtb,
	input ufi_pkg::ufiReqT    reqVtb,
	input ufi_pkg::ufiRamReqT ramReq,
	input ufi_pkg::ufiRspT    rsp,
	input logic               rdyAtb,
	input logic               rdyVtb
);

	logic anyValid;    // Some master asking
	assign anyValid = reqMcs.valid || reqSpi.valid || reqAtb.valid || reqVtb.valid;

	// --------------------------------------------------
	// Ownership and reset
	// --------------------------------------------------
	// Neither fetch port takes the bus straight from the other
	atbHoldsOffVtb: assert property (@(posedge iUfiClk) disable iff (rst) rdyAtb |=> !rdyVtb)
		else $error("VTB took the bus from ATB");

	vtbHoldsOffAtb: assert property (@(posedge iUfiClk) disable iff (rst) rdyVtb |=> !rdyAtb)
		else $error("ATB took the bus from VTB");

	// Second reset edge onward
	rEdQuietInReset: assert property (@(posedge iUfiClk) rst && $past(rst) |-> !rsp.rEd)
		else $error("read strobe during reset");

	// Strobes come from a registered request
	strobeNeedsValid: assert property (@(posedge iUfiClk) disable iff (rst)
		(ramReq.wEd || ramReq.rEd) |-> $past(anyValid))
		else $error("RAM strobe without a master valid");

endmodule

// ==== hw/UfiMemSubsystem.sv ====
/* Memory bus subsystem top: four masters, the arbiter and the RAM block.
   Masters drive request structs; read data comes back on one broadcast response. */
`timescale 1ns/100ps

module UfiMemSubsystem
(
	input  logic            iUfiClk,
	input  logic            rst,
	// Master requests
	input  ufi_pkg::ufiReqT reqMcs,
	input  ufi_pkg::ufiReqT reqSpi,
	input  ufi_pkg::ufiReqT reqAtb,
	input  ufi_pkg::ufiReqT reqVtb,
	// Toward the masters
	output ufi_pkg::ufiRspT rsp,         // Broadcast read data
	output logic            rdy,         // Registered RAM ready
	output logic            rdyAtb,      // ATB owns the bus
	output logic            rdyVtb       // VTB owns the bus
);

	import ufi_pkg::*;

	// --------------------------------------------------
	// Arbiter to RAM wiring
	// --------------------------------------------------
	ufiRamReqT ramReq;
	ufiRspT    ramRsp;
	logic      ramRdy;     // Low during refresh

	// Priority arbiter and return register
	UltraFastInterface ultraFastInterface
	(
		.iUfiClk (iUfiClk),
		.rst     (rst),
		.reqMcs  (reqMcs),
		.reqSpi  (reqSpi),
		.reqAtb  (reqAtb),
		.reqVtb  (reqVtb),
		.ramReq  (ramReq),
		.ramRsp  (ramRsp),
		.ramRdy  (ramRdy),
		.rsp     (rsp),
		.rdy     (rdy),
		.rdyAtb  (rdyAtb),
		.rdyVtb  (rdyVtb)
	);

	// Storage, read pipeline, refresh
	UfiRamBlock ufiRamBlock
	(
		.iUfiClk (iUfiClk),
		.rst     (rst),
		.ramReq  (ramReq),
		.ramRsp  (ramRsp),
		.ramRdy  (ramRdy)
	);

endmodule

// ==== hw/UfiRamBlock.sv ====
/* Synchronous RAM behind the arbiter, with a fixed read pipeline and a periodic refresh.
   Strobes arriving inside the refresh window are dropped; ramRdy shows the window. */
`timescale 1ns/100ps
`include "ufi_cfg.svh"

module UfiRamBlock
(
	input  logic               iUfiClk,
	input  logic               rst,
	input  ufi_pkg::ufiRamReqT ramReq,
	output ufi_pkg::ufiRspT    ramRsp,
	output logic               ramRdy
);

	import ufi_pkg::*;

	localparam int refreshBit = $clog2(`UFI_REFRESH_PERIOD);
	localparam int ramWords   = 1 << `UFI_RAM_DEPTH_BIT;

	logic [`UFI_BUS_WIDTH-1:0]     mem [ramWords];
	logic [`UFI_RAM_DEPTH_BIT-1:0] ramAdrs;        // Low address bits only
	logic [refreshBit-1:0]         refreshCnt;
	logic                          inRefresh;
	logic                          wrAcc;
	logic                          rdAcc;
	logic [`UFI_BUS_WIDTH-1:0]     rdData;         // Array read register
	logic                          rdStb;
	logic [`UFI_BUS_WIDTH-1:0]     rdPipe [`UFI_RD_LATENCY];
	logic [`UFI_RD_LATENCY-1:0]    rEdPipe;

	// --------------------------------------------------
	// Refresh timing
	// --------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (rst)
			refreshCnt <= '0;
		else if (refreshCnt == refreshBit'(`UFI_REFRESH_PERIOD - 1))
			refreshCnt <= '0;                           // Period wrap
		else
			refreshCnt <= refreshCnt + 1'b1;
	end

	// Last few counts of each period are blocked
	assign inRefresh = refreshCnt >= refreshBit'(`UFI_REFRESH_PERIOD - `UFI_REFRESH_CYCLES);
	assign ramRdy    = !inRefresh;

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	assign ramAdrs = ramReq.adrs[`UFI_RAM_DEPTH_BIT-1:0];
	assign wrAcc   = ramReq.wEd && (ramReq.cmd == UFI_WRITE) && ramRdy;
	assign rdAcc   = ramReq.rEd && (ramReq.cmd == UFI_READ) && ramRdy;

	always_ff @(posedge iUfiClk)
	begin
		if (wrAcc)
			mem[ramAdrs] <= ramReq.wd;     // Lands on the strobe edge
		rdData <= mem[ramAdrs];
	end

	// --------------------------------------------------
	// Read pipeline
	// --------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		rdPipe[0] <= rdData;
		for (int i = 1; i < `UFI_RD_LATENCY; i++)
			rdPipe[i] <= rdPipe[i-1];
	end

	always_ff @(posedge iUfiClk)
	begin
		if (rst)
		begin
			rdStb   <= 1'b0;
			rEdPipe <= '0;
		end
		else
		begin
			rdStb   <= rdAcc;
			rEdPipe <= {rEdPipe[`UFI_RD_LATENCY-2:0], rdStb};   // Top bit shifts out
		end
	end

	assign ramRsp.rd  = rdPipe[`UFI_RD_LATENCY-1];
	assign ramRsp.rEd = rEdPipe[`UFI_RD_LATENCY-1];

endmodule

// ==== hw/UltraFastInterface.sv ====
/* Fixed-priority arbiter for four masters sharing one RAM, with ATB/VTB lockout.
   Registers the granted request to the RAM and the RAM response to the masters. */
`timescale 1ns/100ps

module UltraFastInterface
(
	input  logic               iUfiClk,
	input  logic               rst,
	input  ufi_pkg::ufiReqT    reqMcs,     // Write only
	input  ufi_pkg::ufiReqT    reqSpi,     // Debug, read and write
	input  ufi_pkg::ufiReqT    reqAtb,     // Read only
	input  ufi_pkg::ufiReqT    reqVtb,     // Frame buffer, read and write
	output ufi_pkg::ufiRamReqT ramReq,
	input  ufi_pkg::ufiRspT    ramRsp,
	input  logic               ramRdy,
	output ufi_pkg::ufiRspT    rsp,        // Broadcast to every master
	output logic               rdy,
	output logic               rdyAtb,
	output logic               rdyVtb
);

	import ufi_pkg::*;

	ufiGrantE grant;       // Registered owner
	ufiGrantE nextGrant;

	// --------------------------------------------------
	// Owner selection
	// --------------------------------------------------
	// MCS > SPI > ATB > VTB. ATB and VTB wait for each other's flag to drop,
	// so whichever holds the bus keeps it while its valid stays high.
	always_comb
	begin
		if (reqMcs.valid)
			nextGrant = GRANT_MCS;
		else if (reqSpi.valid)
			nextGrant = GRANT_SPI;
		else if (reqAtb.valid && !rdyVtb)
			nextGrant = GRANT_ATB;     // Wins a tie with VTB
		else if (reqVtb.valid && !rdyAtb)
			nextGrant = GRANT_VTB;
		else
			nextGrant = GRANT_NONE;
	end

	always_ff @(posedge iUfiClk)
	begin
		if (rst)
			grant <= GRANT_NONE;
		else
			grant <= nextGrant;
	end

	assign rdyAtb = (grant == GRANT_ATB);  // Owner flags
	assign rdyVtb = (grant == GRANT_VTB);

	// --------------------------------------------------
	// Request register toward the RAM
	// --------------------------------------------------
	// Payload carries no reset
	always_ff @(posedge iUfiClk)
	begin
		case (nextGrant)
			GRANT_MCS:
			begin
				ramReq.adrs <= reqMcs.adrs;
				ramReq.wd   <= reqMcs.wd;
				ramReq.cmd  <= UFI_WRITE;          // Forced write
			end
			GRANT_SPI:
			begin
				ramReq.adrs <= reqSpi.adrs;
				ramReq.wd   <= reqSpi.wd;
				ramReq.cmd  <= reqSpi.cmd;
			end
			GRANT_ATB:
			begin
				ramReq.adrs <= reqAtb.adrs;
				ramReq.wd   <= '0;                 // Nothing to write
				ramReq.cmd  <= UFI_READ;           // Forced read
			end
			GRANT_VTB:
			begin
				ramReq.adrs <= reqVtb.adrs;
				ramReq.wd   <= reqVtb.wd;
				ramReq.cmd  <= reqVtb.cmd;
			end
			default:
			begin
				ramReq.adrs <= '0;
				ramReq.wd   <= '0;
				ramReq.cmd  <= UFI_READ;
			end
		endcase
	end

	// Strobes split by command, idle when nobody owns the bus
	always_ff @(posedge iUfiClk)
	begin
		if (rst)
		begin
			ramReq.wEd <= 1'b0;
			ramReq.rEd <= 1'b0;
		end
		else
		begin
			case (nextGrant)
				GRANT_MCS:
				begin
					ramReq.wEd <= reqMcs.ed;
					ramReq.rEd <= 1'b0;
				end
				GRANT_SPI:
				begin
					ramReq.wEd <= reqSpi.ed && (reqSpi.cmd == UFI_WRITE);
					ramReq.rEd <= reqSpi.ed && (reqSpi.cmd == UFI_READ);
				end
				GRANT_ATB:
				begin
					ramReq.wEd <= 1'b0;
					ramReq.rEd <= reqAtb.ed;
				end
				GRANT_VTB:
				begin
					ramReq.wEd <= reqVtb.ed && (reqVtb.cmd == UFI_WRITE);
					ramReq.rEd <= reqVtb.ed && (reqVtb.cmd == UFI_READ);
				end
				default:
				begin
					ramReq.wEd <= 1'b0;
					ramReq.rEd <= 1'b0;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// Return stage
	// --------------------------------------------------
	// Masters count their own read strobes, no tag needed
	always_ff @(posedge iUfiClk)
	begin
		rsp.rd <= ramRsp.rd;
		if (rst)
		begin
			rsp.rEd <= 1'b0;
			rdy     <= 1'b0;
		end
		else
		begin
			rsp.rEd <= ramRsp.rEd;
			rdy     <= ramRdy;         // One cycle behind RAM ready
		end
	end

endmodule

// ==== hw/ufi_pkg.sv ====
/* Shared bus types for the arbiter, the RAM block and the masters.
   Import inside module bodies; use scoped names in port lists. */
`include "ufi_cfg.svh"

package ufi_pkg;

	// --------------------------------------------------
	// Enums
	// --------------------------------------------------
	typedef enum logic
	{
		UFI_WRITE = 1'b0,
		UFI_READ  = 1'b1
	} ufiCmdE;

	// Current bus owner
	typedef enum logic [2:0]
	{
		GRANT_NONE,
		GRANT_MCS,
		GRANT_SPI,
		GRANT_ATB,
		GRANT_VTB
	} ufiGrantE;

	// --------------------------------------------------
	// Structs
	// --------------------------------------------------
	typedef struct packed
	{
		logic                       valid;  // Held for whole transfer
		ufiCmdE                     cmd;
		logic [`UFI_ADRS_BIT-1:0]   adrs;
		logic [`UFI_BUS_WIDTH-1:0]  wd;
		logic                       ed;     // One strobe per access
	} ufiReqT;

	typedef struct packed
	{
		logic [`UFI_ADRS_BIT-1:0]   adrs;
		logic [`UFI_BUS_WIDTH-1:0]  wd;
		logic                       wEd;
		logic                       rEd;
		ufiCmdE                     cmd;
	} ufiRamReqT;

	// RAM return and master broadcast share this
	typedef struct packed
	{
		logic [`UFI_BUS_WIDTH-1:0]  rd;
		logic                       rEd;
	} ufiRspT;

endpackage

// ==== include/ufi_cfg.svh ====
/* Build-time sizes for the memory bus subsystem.
   Include wherever bus, RAM or refresh dimensions are needed. */
`ifndef UFI_CFG_SVH
`define UFI_CFG_SVH

// --------------------------------------------------
// Bus geometry
// --------------------------------------------------
`define UFI_BUS_WIDTH       8       // Data word width
`define UFI_ADRS_BIT        16      // Master address width

// --------------------------------------------------
// RAM geometry and timing
// --------------------------------------------------
`define UFI_RAM_DEPTH_BIT   10      // Stored address bits, upper bits ignored
`define UFI_RD_LATENCY      2       // Read shift pipeline depth

// Refresh window sits at the tail of each period
`define UFI_REFRESH_PERIOD  64      // Cycles per refresh period
`define UFI_REFRESH_CYCLES  2       // Blocked cycles at end of period

`endif
